// ==== level_two_trigger.f ====
+incdir+logic
logic/l2_trig_pkg.sv
logic/sector_mapper.sv
logic/sector_coincidence.sv
logic/trigger_combiner.sv
logic/meta_delay.sv
logic/level_two_trigger.sv
testbench/tb_clock_gen.sv
testbench/level_two_trigger_assert.sv
testbench/tb_level_two_trigger.sv

// ==== logic/l2_trig_macros.svh ====
`ifndef L2_TRIG_MACROS_SVH
`define L2_TRIG_MACROS_SVH

// array geometry
`define L2_NLINK    4
`define L2_NPOL     2
`define L2_NSECT    12
`define L2_NREGION  4

// link word widths
`define L2_TRIG_W   8
`define L2_META_W   48

// enabled cycles from input sample to trig_o and delayed metadata
`define L2_LATENCY  4

// trigger word bit positions
`define L2_AUX_BIT  7
`define L2_LF_BIT   6

`endif

// ==== logic/l2_trig_pkg.sv ====
`default_nettype none

`include "l2_trig_macros.svh"

package l2_trig_pkg;

    // raw trigger word from one link
    typedef logic [`L2_TRIG_W-1:0] trig_word_t;

    // raw metadata word from one link, one byte per digitizer slot
    typedef logic [`L2_META_W-1:0] meta_word_t;

    // region masks of all sectors in one polarization, 4 bits per sector
    typedef logic [`L2_NSECT*`L2_NREGION-1:0] sect_mask_t;

    // one scaler pulse per sector
    typedef logic [`L2_NSECT-1:0] scaler_vec_t;

    // hpol scalers in the low half, vpol in the high half
    typedef logic [`L2_NPOL*`L2_NSECT-1:0] l2_scaler_t;

endpackage

`default_nettype wire

// ==== logic/level_two_trigger.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "l2_trig_macros.svh"

module level_two_trigger (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    ce_i,
    input  logic                    logictype_i,
    input  logic                    holdoff_i,
    input  logic                    dead_i,
    input  l2_trig_pkg::trig_word_t tio0_trig_i,
    input  l2_trig_pkg::trig_word_t tio1_trig_i,
    input  l2_trig_pkg::trig_word_t tio2_trig_i,
    input  l2_trig_pkg::trig_word_t tio3_trig_i,
    input  l2_trig_pkg::meta_word_t tio0_meta_i,
    input  l2_trig_pkg::meta_word_t tio1_meta_i,
    input  l2_trig_pkg::meta_word_t tio2_meta_i,
    input  l2_trig_pkg::meta_word_t tio3_meta_i,
    output l2_trig_pkg::meta_word_t tio0_meta_o,
    output l2_trig_pkg::meta_word_t tio1_meta_o,
    output l2_trig_pkg::meta_word_t tio2_meta_o,
    output l2_trig_pkg::meta_word_t tio3_meta_o,
    output l2_trig_pkg::l2_scaler_t leveltwo_o,
    output logic                    trig_o
);
    import l2_trig_pkg::*;

    sect_mask_t          low_mask [`L2_NPOL];
    sect_mask_t          high_mask [`L2_NPOL];
    logic [`L2_NPOL-1:0] l2_trig;

    sector_mapper u_mapper (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .ce_i        (ce_i),
        .meta0_i     (tio0_meta_i),
        .meta1_i     (tio1_meta_i),
        .meta2_i     (tio2_meta_i),
        .meta3_i     (tio3_meta_i),
        .low_mask_o  (low_mask),
        .high_mask_o (high_mask)
    );

    // polarization 0 is hpol, 1 is vpol
    for (genvar p = 0; p < `L2_NPOL; p++) begin : g_pol
        sector_coincidence u_coinc (
            .clk_i       (clk_i),
            .rst_n_i     (rst_n_i),
            .ce_i        (ce_i),
            .logictype_i (logictype_i),
            .low_mask_i  (low_mask[p]),
            .high_mask_i (high_mask[p]),
            .l2_trig_o   (l2_trig[p]),
            .scaler_o    (leveltwo_o[p*`L2_NSECT +: `L2_NSECT])
        );
    end

    trigger_combiner u_comb (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .ce_i      (ce_i),
        .holdoff_i (holdoff_i),
        .dead_i    (dead_i),
        .trig0_i   (tio0_trig_i),
        .trig1_i   (tio1_trig_i),
        .trig2_i   (tio2_trig_i),
        .trig3_i   (tio3_trig_i),
        .l2_trig_i (l2_trig),
        .trig_o    (trig_o)
    );

    // metadata leaves together with the trigger it produced
    meta_delay u_meta0 (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .ce_i    (ce_i),
        .meta_i  (tio0_meta_i),
        .meta_o  (tio0_meta_o)
    );

    meta_delay u_meta1 (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .ce_i    (ce_i),
        .meta_i  (tio1_meta_i),
        .meta_o  (tio1_meta_o)
    );

    meta_delay u_meta2 (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .ce_i    (ce_i),
        .meta_i  (tio2_meta_i),
        .meta_o  (tio2_meta_o)
    );

    meta_delay u_meta3 (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .ce_i    (ce_i),
        .meta_i  (tio3_meta_i),
        .meta_o  (tio3_meta_o)
    );

endmodule

`default_nettype wire

// ==== logic/meta_delay.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "l2_trig_macros.svh"

module meta_delay #(
    parameter int DEPTH = `L2_LATENCY
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    ce_i,
    input  l2_trig_pkg::meta_word_t meta_i,
    output l2_trig_pkg::meta_word_t meta_o
);
    import l2_trig_pkg::*;

    meta_word_t sr_q [DEPTH];

    // shifts only on enabled cycles, same as the trigger pipeline
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < DEPTH; k++) begin
                sr_q[k] <= '0;
            end
        end else if (ce_i) begin
            sr_q[0] <= meta_i;
            for (int k = 1; k < DEPTH; k++) begin
                sr_q[k] <= sr_q[k-1];
            end
        end
    end

    assign meta_o = sr_q[DEPTH-1];

endmodule

`default_nettype wire

// ==== logic/sector_coincidence.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "l2_trig_macros.svh"

module sector_coincidence (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     ce_i,
    input  logic                     logictype_i,
    input  l2_trig_pkg::sect_mask_t  low_mask_i,
    input  l2_trig_pkg::sect_mask_t  high_mask_i,
    output logic                     l2_trig_o,
    output l2_trig_pkg::scaler_vec_t scaler_o
);
    import l2_trig_pkg::*;

    localparam int MASK_W = $bits(sect_mask_t);

    sect_mask_t low_prev_q;
    sect_mask_t high_prev_q;
    sect_mask_t low_str_q;
    sect_mask_t high_str_q;
    sect_mask_t high_rot;
    sect_mask_t coinc;

    // logic type of the newest sample in the stretch
    logic lt_map_q;
    logic lt_str_q;

    scaler_vec_t act;
    scaler_vec_t act_q;
    scaler_vec_t act_qq;

    // sector i sees the high mask of sector i+1, sector 11 wraps to 0
    assign high_rot = {high_str_q[`L2_NREGION-1:0], high_str_q[MASK_W-1:`L2_NREGION]};

    // logictype 0 is AND, 1 is OR
    assign coinc = lt_str_q ? (low_str_q | high_rot) : (low_str_q & high_rot);

    always_comb begin
        for (int s = 0; s < `L2_NSECT; s++) begin
            act[s] = |coinc[`L2_NREGION*s +: `L2_NREGION];
        end
    end

    // stage 1, stretch each mask over the current and previous sample
    // logictype follows its sample through the mapper and stretch stages
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            low_prev_q  <= '0;
            high_prev_q <= '0;
            low_str_q   <= '0;
            high_str_q  <= '0;
            lt_map_q    <= 1'b0;
            lt_str_q    <= 1'b0;
        end else if (ce_i) begin
            low_prev_q  <= low_mask_i;
            high_prev_q <= high_mask_i;
            low_str_q   <= low_mask_i | low_prev_q;
            high_str_q  <= high_mask_i | high_prev_q;
            lt_map_q    <= logictype_i;
            lt_str_q    <= lt_map_q;
        end
    end

    // stage 2 trigger, scaler edge lands one stage later
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            l2_trig_o <= 1'b0;
            act_q     <= '0;
            act_qq    <= '0;
            scaler_o  <= '0;
        end else if (ce_i) begin
            l2_trig_o <= |coinc;
            act_q     <= act;
            act_qq    <= act_q;
            scaler_o  <= act_q & ~act_qq;
        end
    end

endmodule

`default_nettype wire

// ==== logic/sector_mapper.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "l2_trig_macros.svh"

module sector_mapper (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    ce_i,
    input  l2_trig_pkg::meta_word_t meta0_i,
    input  l2_trig_pkg::meta_word_t meta1_i,
    input  l2_trig_pkg::meta_word_t meta2_i,
    input  l2_trig_pkg::meta_word_t meta3_i,
    output l2_trig_pkg::sect_mask_t low_mask_o [`L2_NPOL],
    output l2_trig_pkg::sect_mask_t high_mask_o [`L2_NPOL]
);
    import l2_trig_pkg::*;

    localparam int HALF = `L2_NSECT / 2;

    // hpol walks link 0 slots 5..0 then link 1 slots 0..5
    // vpol does the same with links 3 and 2
    localparam int LINK_A [`L2_NPOL] = '{0, 3};
    localparam int LINK_B [`L2_NPOL] = '{1, 2};

    meta_word_t meta [`L2_NLINK];
    sect_mask_t low_d [`L2_NPOL];
    sect_mask_t high_d [`L2_NPOL];

    assign meta[0] = meta0_i;
    assign meta[1] = meta1_i;
    assign meta[2] = meta2_i;
    assign meta[3] = meta3_i;

    always_comb begin
        logic [7:0] slot_byte;
        for (int p = 0; p < `L2_NPOL; p++) begin
            for (int s = 0; s < `L2_NSECT; s++) begin
                if (s < HALF) begin
                    slot_byte = meta[LINK_A[p]][8*(HALF-1-s) +: 8];
                end else begin
                    slot_byte = meta[LINK_B[p]][8*(s-HALF) +: 8];
                end
                // low nibble is the low threshold, high nibble the high one
                low_d[p][`L2_NREGION*s +: `L2_NREGION]  = slot_byte[3:0];
                high_d[p][`L2_NREGION*s +: `L2_NREGION] = slot_byte[7:4];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int p = 0; p < `L2_NPOL; p++) begin
                low_mask_o[p]  <= '0;
                high_mask_o[p] <= '0;
            end
        end else if (ce_i) begin
            for (int p = 0; p < `L2_NPOL; p++) begin
                low_mask_o[p]  <= low_d[p];
                high_mask_o[p] <= high_d[p];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/trigger_combiner.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "l2_trig_macros.svh"

module trigger_combiner (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    ce_i,
    input  logic                    holdoff_i,
    input  logic                    dead_i,
    input  l2_trig_pkg::trig_word_t trig0_i,
    input  l2_trig_pkg::trig_word_t trig1_i,
    input  l2_trig_pkg::trig_word_t trig2_i,
    input  l2_trig_pkg::trig_word_t trig3_i,
    input  logic [`L2_NPOL-1:0]     l2_trig_i,
    output logic                    trig_o
);
    import l2_trig_pkg::*;

    // aux/lf ride alongside the mapper and both coincidence stages
    localparam int DLY = `L2_LATENCY - 1;

    trig_word_t trig_w [`L2_NLINK];

    logic       aux_now;
    logic [1:0] lf_now;
    logic       aux_al;
    logic [1:0] lf_al;
    logic       any_trig;

    // bit 2 is aux, bits 1:0 are the two lf triggers
    logic [2:0] dly_q [DLY];

    assign trig_w[0] = trig0_i;
    assign trig_w[1] = trig1_i;
    assign trig_w[2] = trig2_i;
    assign trig_w[3] = trig3_i;

    always_comb begin
        aux_now = 1'b0;
        for (int l = 0; l < `L2_NLINK; l++) begin
            aux_now = aux_now | trig_w[l][`L2_AUX_BIT];
        end
    end

    // lf pairs follow the polarization split of the links
    assign lf_now[0] = trig_w[0][`L2_LF_BIT] | trig_w[1][`L2_LF_BIT];
    assign lf_now[1] = trig_w[2][`L2_LF_BIT] | trig_w[3][`L2_LF_BIT];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < DLY; k++) begin
                dly_q[k] <= '0;
            end
        end else if (ce_i) begin
            dly_q[0] <= {aux_now, lf_now};
            for (int k = 1; k < DLY; k++) begin
                dly_q[k] <= dly_q[k-1];
            end
        end
    end

    assign aux_al = dly_q[DLY-1][2];
    assign lf_al  = dly_q[DLY-1][1:0];

    assign any_trig = aux_al | (|lf_al) | (|l2_trig_i);

    // registered every clock so a ce_i low cycle always clears the pulse
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            trig_o <= 1'b0;
        end else begin
            trig_o <= ce_i & ~holdoff_i & ~dead_i & any_trig;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/level_two_trigger_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module level_two_trigger_assert (
    input wire logic clk_i,
    input wire logic rst_n_i,
    input wire logic ce_i,
    input wire logic holdoff_i,
    input wire logic dead_i,
    input wire logic trig_o
);

    // reset clears the master trigger on the next edge
    a_reset_low: assert property (@(posedge clk_i) !rst_n_i |=> !trig_o)
        else $error("trig_o high after a reset edge");

    // no pulse out of a disabled cycle
    a_ce_low: assert property (@(posedge clk_i) !ce_i |=> !trig_o)
        else $error("trig_o high after ce_i low");

    // veto inputs block the pulse
    a_veto: assert property (@(posedge clk_i) (holdoff_i || dead_i) |=> !trig_o)
        else $error("trig_o high while holdoff_i or dead_i was set");

endmodule

bind level_two_trigger level_two_trigger_assert u_assert (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .ce_i      (ce_i),
    .holdoff_i (holdoff_i),
    .dead_i    (dead_i),
    .trig_o    (trig_o)
);

`default_nettype wire

// ==== testbench/level_two_trigger_testdata.txt ====
# ce lt holdoff dead trig0..trig3 meta0..meta3 exp_trig exp_leveltwo
# expected values are the outputs right after the edge that samples the line
1 0 0 0 00 00 00 00 102030405060 708090a0b0c0 f0e0d0c0b0a0 908070605040 0 000000
1 0 0 0 00 00 00 00 504030201000 000000000000 102030405060 a0a0a0a0a0a0 0 000000
1 0 0 0 00 00 00 00 000000000000 000000000000 000000000000 000000000000 0 000000
1 0 0 0 00 00 00 00 0f0f0f0f0f0f 0f0f0f0f0f0f 0f0f0f0f0f0f 0f0f0f0f0f0f 0 000000
1 0 0 0 00 00 00 00 000000000000 000000000000 000000000000 000000000000 0 000000
1 0 0 0 00 00 00 00 000000000000 000000000000 000000000000 000000000000 0 000000
1 0 0 0 00 00 00 00 000000010000 000000000000 000000000000 000000000000 0 000000
1 0 0 0 00 00 00 00 000000001000 000000000000 000000000000 000000000000 0 000000
1 0 0 0 00 00 00 00 000000000000 000000000000 000000000000 000000000000 0 000000
1 0 0 0 00 00 00 00 000000000000 000000000000 000000000000 000000000000 0 000000
1 0 0 0 00 00 00 00 000000000000 000000000000 040000000000 000000000000 1 000008
1 0 0 0 00 00 00 00 000000000000 000000000000 000000000000 400000000000 0 000000
1 0 0 0 00 00 00 00 000000000000 000000000000 000000000000 000000000000 0 000000
1 0 0 0 00 00 00 00 000000000000 000000000000 000000000000 000000000000 0 000000
1 1 0 0 00 00 00 00 000000000000 000000000000 000000000000 000000000000 1 800000
1 1 0 0 00 00 00 00 000000000000 000000000000 000000000000 000000000000 0 000000
1 1 0 0 00 00 00 00 000000000000 000000000200 000000000000 000000000000 0 000000
1 1 0 0 00 00 00 00 000000000000 000000000200 000000000000 000000000000 0 000000
1 1 0 0 00 00 00 00 000000000000 000000000200 000000000000 000000000000 0 000000
1 1 0 0 00 00 00 00 000000000000 000000000000 000000000000 000000000000 1 000080
1 1 0 0 00 00 00 00 000000000000 000000000000 000000000000 000000000000 1 000000
1 1 0 0 00 00 00 00 000000000000 000000000000 000000000000 000000000000 1 000000
1 1 0 0 00 00 00 00 000000000000 000000000000 000000000000 000000000000 1 000000
1 0 0 0 00 00 00 00 000000000000 000000000000 000000000000 000000000000 0 000000
1 0 0 0 80 00 00 00 000000000000 000000000000 000000000000 000000000000 0 000000
1 0 0 0 00 00 3f 00 000000000000 000000000000 000000000000 000000000000 0 000000
1 0 0 0 00 00 00 40 000000000000 000000000000 000000000000 000000000000 0 000000
1 0 0 0 00 00 00 00 000000000000 000000000000 000000000000 000000000000 1 000000
1 0 0 0 00 40 00 00 000000000000 000000000000 000000000000 000000000000 0 000000
1 0 0 0 00 00 00 00 000000000000 000000000000 000000000000 000000000000 1 000000
1 0 0 0 00 00 80 00 000000000000 000000000000 000000000000 000000000000 0 000000
1 0 0 0 00 00 00 00 000000000000 000000000000 000000000000 000000000000 1 000000
1 0 0 0 80 00 00 00 000000000000 000000000000 000000000000 000000000000 0 000000
1 0 0 0 00 80 00 00 000000000000 000000000000 000000000000 000000000000 1 000000
1 0 0 0 00 00 00 00 000000000000 000000000000 000000000000 000000000000 0 000000
1 0 1 0 00 00 00 00 000000000000 000000000000 000000000000 000000000000 0 000000
1 0 0 1 00 00 00 00 000000000000 000000000000 000000000000 000000000000 0 000000
1 0 0 0 80 00 00 00 000000010000 000000000000 000000000000 000000000000 0 000000
0 0 0 0 80 00 00 00 ffffffffffff ffffffffffff ffffffffffff ffffffffffff 0 000000
0 0 0 0 80 00 00 00 ffffffffffff ffffffffffff ffffffffffff ffffffffffff 0 000000
1 0 0 0 00 00 00 00 000000001000 000000000000 000000000000 000000000000 0 000000
1 0 0 0 00 00 00 00 000000000000 000000000000 000000000000 000000000000 0 000000
1 0 0 0 00 00 00 00 000000000000 000000000000 000000000000 000000000000 1 000000
1 0 0 0 00 00 00 00 000000000000 000000000000 000000000000 000000000000 1 000008
1 0 0 0 00 00 00 00 000000000000 000000000000 000000000000 000000000000 0 000000
1 0 0 0 00 00 00 00 000000000000 000000000000 000000000000 000000000000 0 000000

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);
    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // reset held for 8 rising edges, released on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_level_two_trigger.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "l2_trig_macros.svh"

module tb_level_two_trigger;
    import l2_trig_pkg::*;

    logic       clk_i;
    logic       rst_n_i;
    logic       ce_i;
    logic       logictype_i;
    logic       holdoff_i;
    logic       dead_i;
    trig_word_t trig_in [`L2_NLINK];
    meta_word_t meta_in [`L2_NLINK];
    meta_word_t meta_out [`L2_NLINK];
    l2_scaler_t leveltwo_o;
    logic       trig_o;

    // one entry per vector of the data file
    logic       v_ce [$];
    logic       v_lt [$];
    logic       v_ho [$];
    logic       v_dd [$];
    logic [31:0] v_trig [$];
    logic [4*`L2_META_W-1:0] v_meta [$];
    logic       v_exp_trig [$];
    l2_scaler_t v_exp_l2 [$];

    // metadata of enabled cycles still inside the delay line
    logic [4*`L2_META_W-1:0] meta_hist [$];
    logic [4*`L2_META_W-1:0] exp_meta;

    int cycle_cnt = 0;
    int cycle_limit = 0;

    tb_clock_gen u_clk (
        .clk_o   (clk_i),
        .rst_n_o (rst_n_i)
    );

    level_two_trigger DUT (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .ce_i        (ce_i),
        .logictype_i (logictype_i),
        .holdoff_i   (holdoff_i),
        .dead_i      (dead_i),
        .tio0_trig_i (trig_in[0]),
        .tio1_trig_i (trig_in[1]),
        .tio2_trig_i (trig_in[2]),
        .tio3_trig_i (trig_in[3]),
        .tio0_meta_i (meta_in[0]),
        .tio1_meta_i (meta_in[1]),
        .tio2_meta_i (meta_in[2]),
        .tio3_meta_i (meta_in[3]),
        .tio0_meta_o (meta_out[0]),
        .tio1_meta_o (meta_out[1]),
        .tio2_meta_o (meta_out[2]),
        .tio3_meta_o (meta_out[3]),
        .leveltwo_o  (leveltwo_o),
        .trig_o      (trig_o)
    );

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_trig(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_failure($sformatf("[FAIL] t=%0t %s expected %b got %b",
                                      $time, name, exp, act));
        end
    endtask

    task automatic check_scaler(input string name, input l2_scaler_t exp, input l2_scaler_t act);
        if (act !== exp) begin
            stop_on_failure($sformatf("[FAIL] t=%0t %s expected %h got %h",
                                      $time, name, exp, act));
        end
    endtask

    task automatic check_meta(input string name, input meta_word_t exp, input meta_word_t act);
        if (act !== exp) begin
            stop_on_failure($sformatf("[FAIL] t=%0t %s expected %h got %h",
                                      $time, name, exp, act));
        end
    endtask

    task automatic load_vectors();
        int fd;
        int n;
        string line;
        logic c;
        logic lt;
        logic ho;
        logic dd;
        logic [7:0] t0, t1, t2, t3;
        meta_word_t m0, m1, m2, m3;
        logic et;
        l2_scaler_t el;
        fd = $fopen("testbench/level_two_trigger_testdata.txt", "r");
        if (fd == 0) begin
            stop_on_failure("could not open the test data file");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        c, lt, ho, dd, t0, t1, t2, t3, m0, m1, m2, m3, et, el);
            if (n != 14) begin
                stop_on_failure($sformatf("malformed test data line: %s", line));
            end
            v_ce.push_back(c);
            v_lt.push_back(lt);
            v_ho.push_back(ho);
            v_dd.push_back(dd);
            v_trig.push_back({t3, t2, t1, t0});
            v_meta.push_back({m3, m2, m1, m0});
            v_exp_trig.push_back(et);
            v_exp_l2.push_back(el);
        end
        $fclose(fd);
    endtask

    task automatic drive_vector(input int i);
        ce_i        = v_ce[i];
        logictype_i = v_lt[i];
        holdoff_i   = v_ho[i];
        dead_i      = v_dd[i];
        for (int l = 0; l < `L2_NLINK; l++) begin
            trig_in[l] = v_trig[i][8*l +: 8];
            meta_in[l] = v_meta[i][`L2_META_W*l +: `L2_META_W];
        end
        // meta_o shows the sample of 4 enabled cycles back, frozen while ce is low
        if (v_ce[i]) begin
            meta_hist.push_back(v_meta[i]);
            exp_meta = meta_hist.pop_front();
        end
    endtask

    task automatic check_vector(input int i);
        check_trig("trig_o", v_exp_trig[i], trig_o);
        check_scaler("leveltwo_o", v_exp_l2[i], leveltwo_o);
        for (int l = 0; l < `L2_NLINK; l++) begin
            check_meta($sformatf("tio%0d_meta_o", l),
                       exp_meta[`L2_META_W*l +: `L2_META_W], meta_out[l]);
        end
    endtask

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            stop_on_failure("timeout, vectors did not finish in time");
        end
    end

    initial begin
        ce_i        = 1'b0;
        logictype_i = 1'b0;
        holdoff_i   = 1'b0;
        dead_i      = 1'b0;
        for (int l = 0; l < `L2_NLINK; l++) begin
            trig_in[l] = '0;
            meta_in[l] = '0;
        end
        exp_meta = '0;
        for (int k = 0; k < `L2_LATENCY - 1; k++) begin
            meta_hist.push_back('0);
        end
        load_vectors();
        // reset cycles plus one per vector plus margin
        cycle_limit = 8 + v_ce.size() + 40;
        wait (rst_n_i === 1'b1);
        for (int i = 0; i < v_ce.size(); i++) begin
            @(negedge clk_i);
            if (i > 0) begin
                check_vector(i - 1);
            end
            drive_vector(i);
        end
        @(negedge clk_i);
        check_vector(v_ce.size() - 1);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
